//--- source/snake_pkg.sv
package snake_pkg;

    // ----------------------------------------
    // Travel directions and coordinates
    // ----------------------------------------
    typedef enum logic [1:0] {
        DIR_RIGHT = 2'd0,
        DIR_LEFT  = 2'd1,
        DIR_DOWN  = 2'd2,
        DIR_UP    = 2'd3
    } dir_t;

    typedef logic [7:0] cell_x_t;
    typedef logic [6:0] cell_y_t;
    typedef logic [9:0] pix_x_t;
    typedef logic [8:0] pix_y_t;

    // RGB, 3 bits per channel
    typedef logic [8:0] color_t;

    localparam color_t SNAKE_COLOR = 9'b000_111_000;
    localparam color_t FOOD_COLOR  = 9'b111_000_000;
    localparam color_t BG_COLOR    = 9'b010_001_000;

    localparam int GRID_W = 160;
    localparam int GRID_H = 120;

    // ----------------------------------------
    // PS/2 set 2 codes
    // ----------------------------------------
    localparam logic [7:0] KEY_UP       = 8'h75;
    localparam logic [7:0] KEY_DOWN     = 8'h72;
    localparam logic [7:0] KEY_LEFT     = 8'h6B;
    localparam logic [7:0] KEY_RIGHT    = 8'h74;
    localparam logic [7:0] PREFIX_EXT   = 8'hE0;
    localparam logic [7:0] PREFIX_BREAK = 8'hF0;

endpackage

//--- source/ps2_direction_decoder.sv
`timescale 1ns/1ps

module ps2_direction_decoder (
    input  logic            CLOCK_50,
    input  logic            resetn,
    input  logic            ps2_clk,
    input  logic            ps2_dat,
    output snake_pkg::dir_t dir
);

    logic [1:0]  clk_sync;
    logic [1:0]  dat_sync;
    logic        clk_prev;
    logic        fall;
    logic [10:0] frame;
    logic [3:0]  bit_cnt;
    logic        frame_done;
    logic        frame_ok;
    logic [7:0]  code;
    logic        got_e0;
    logic        got_f0;

    // ----------------------------------------
    // Synchronisers and edge detect
    // ----------------------------------------
    // Lines idle high
    always_ff @(posedge CLOCK_50 or negedge resetn) begin
        if (!resetn) begin
            clk_sync <= 2'b11;
            dat_sync <= 2'b11;
            clk_prev <= 1'b1;
        end else begin
            clk_sync <= {clk_sync[0], ps2_clk};
            dat_sync <= {dat_sync[0], ps2_dat};
            clk_prev <= clk_sync[1];
        end
    end

    assign fall = clk_prev & ~clk_sync[1];

    // ----------------------------------------
    // Frame assembly
    // ----------------------------------------
    // LSB first, so the start bit ends up in frame[0]
    always_ff @(posedge CLOCK_50) begin
        if (fall) begin
            frame <= {dat_sync[1], frame[10:1]};
        end
    end

    always_ff @(posedge CLOCK_50 or negedge resetn) begin
        if (!resetn) begin
            bit_cnt <= 4'd0;
        end else if (frame_done) begin
            bit_cnt <= 4'd0;
        end else if (fall) begin
            bit_cnt <= bit_cnt + 4'd1;
        end
    end

    assign frame_done = (bit_cnt == 4'd11);
    assign code       = frame[8:1];
    // Start low, stop high, odd parity over data and parity bit
    assign frame_ok   = !frame[0] && frame[10] && (^frame[9:1]);

    // Prefix tracking and arrow make-codes
    always_ff @(posedge CLOCK_50 or negedge resetn) begin
        if (!resetn) begin
            got_e0 <= 1'b0;
            got_f0 <= 1'b0;
            dir    <= snake_pkg::DIR_RIGHT;
        end else if (frame_done && frame_ok) begin
            if (code == snake_pkg::PREFIX_EXT) begin
                got_e0 <= 1'b1;
            end else if (code == snake_pkg::PREFIX_BREAK) begin
                got_f0 <= 1'b1;
            end else begin
                got_e0 <= 1'b0;
                got_f0 <= 1'b0;
                if (got_e0 && !got_f0) begin
                    case (code)
                        snake_pkg::KEY_UP:    dir <= snake_pkg::DIR_UP;
                        snake_pkg::KEY_DOWN:  dir <= snake_pkg::DIR_DOWN;
                        snake_pkg::KEY_LEFT:  dir <= snake_pkg::DIR_LEFT;
                        snake_pkg::KEY_RIGHT: dir <= snake_pkg::DIR_RIGHT;
                        default: ;
                    endcase
                end
            end
        end
    end

    a_bit_cnt_range: assert property (
        @(posedge CLOCK_50) disable iff (!resetn) bit_cnt <= 4'd11
    );

endmodule

//--- source/snake_engine.sv
`timescale 1ns/1ps

module snake_engine #(
    parameter int STEP        = 4,
    parameter int MAX_LEN     = 64,
    parameter int INIT_LEN    = 8,
    parameter int TICK_CYCLES = 20_000_000
) (
    input  logic               CLOCK_50,
    input  logic               resetn,
    input  snake_pkg::dir_t    dir,
    output logic               draw_req,
    output snake_pkg::cell_x_t draw_x,
    output snake_pkg::cell_y_t draw_y,
    output snake_pkg::color_t  draw_color,
    output logic               draw_gap,
    input  logic               draw_ack,
    output logic [7:0]         score,
    output logic               game_over
);

    localparam int TW = $clog2(TICK_CYCLES);
    localparam int LW = $clog2(MAX_LEN + 1);
    localparam int IW = $clog2(MAX_LEN);

    typedef enum logic [2:0] {S_FOOD, S_SEGS, S_WAIT, S_ERASE, S_MOVE, S_OVER} state_t;

    state_t             state;
    logic [TW-1:0]      tick_cnt;
    logic               tick;
    logic [15:0]        lfsr;
    snake_pkg::cell_x_t body_x [MAX_LEN];
    snake_pkg::cell_y_t body_y [MAX_LEN];
    logic [LW-1:0]      len;
    logic [IW-1:0]      seg;
    logic [IW-1:0]      tail_idx;
    snake_pkg::cell_x_t food_x, nx, mv_x, req_x;
    snake_pkg::cell_y_t food_y, ny, mv_y, req_y;
    snake_pkg::color_t  req_color;
    logic               req_gap;
    logic               paint;
    logic               hs_done;
    snake_pkg::dir_t    heading;
    logic               ate;
    logic               wall;
    logic               self_hit;
    logic               eat;

    // ----------------------------------------
    // Game tick and food LFSR
    // ----------------------------------------
    assign tick = (tick_cnt == TW'(TICK_CYCLES - 1));

    always_ff @(posedge CLOCK_50 or negedge resetn) begin
        if (!resetn) begin
            tick_cnt <= '0;
            lfsr     <= 16'hACE1;
        end else begin
            tick_cnt <= tick ? '0 : tick_cnt + 1'b1;
            lfsr     <= {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
        end
    end

    // Next head cell, wall and body hits
    always_comb begin
        nx   = body_x[0];
        ny   = body_y[0];
        wall = 1'b0;
        case (heading)
            snake_pkg::DIR_RIGHT: begin
                nx   = body_x[0] + snake_pkg::cell_x_t'(STEP);
                wall = body_x[0] >= snake_pkg::cell_x_t'(snake_pkg::GRID_W - STEP);
            end
            snake_pkg::DIR_LEFT: begin
                nx   = body_x[0] - snake_pkg::cell_x_t'(STEP);
                wall = body_x[0] < snake_pkg::cell_x_t'(STEP);
            end
            snake_pkg::DIR_DOWN: begin
                ny   = body_y[0] + snake_pkg::cell_y_t'(STEP);
                wall = body_y[0] >= snake_pkg::cell_y_t'(snake_pkg::GRID_H - STEP);
            end
            default: begin
                ny   = body_y[0] - snake_pkg::cell_y_t'(STEP);
                wall = body_y[0] < snake_pkg::cell_y_t'(STEP);
            end
        endcase
        self_hit = 1'b0;
        for (int i = 1; i < MAX_LEN; i++) begin
            if (i < int'(len) && nx == body_x[i] && ny == body_y[i]) begin
                self_hit = 1'b1;
            end
        end
        eat = (nx == food_x) && (ny == food_y);
    end

    // ----------------------------------------
    // Block requests to the painter
    // ----------------------------------------
    assign tail_idx = IW'(len - 1'b1);
    assign hs_done  = draw_req && draw_ack;

    always_comb begin
        paint     = 1'b1;
        req_x     = food_x;
        req_y     = food_y;
        req_color = snake_pkg::FOOD_COLOR;
        req_gap   = 1'b0;
        case (state)
            S_FOOD: ;
            S_SEGS: begin
                req_x     = body_x[seg];
                req_y     = body_y[seg];
                req_color = snake_pkg::SNAKE_COLOR;
                req_gap   = 1'b1;
            end
            S_ERASE: begin
                // Food block when eating, tail block otherwise
                if (!ate) begin
                    req_x = body_x[tail_idx];
                    req_y = body_y[tail_idx];
                end
                req_color = snake_pkg::BG_COLOR;
            end
            default: paint = 1'b0;
        endcase
    end

    always_ff @(posedge CLOCK_50 or negedge resetn) begin
        if (!resetn) begin
            draw_req <= 1'b0;
        end else if (paint && !draw_req && !draw_ack) begin
            draw_req <= 1'b1;
        end else if (hs_done) begin
            draw_req <= 1'b0;
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (paint && !draw_req && !draw_ack) begin
            draw_x     <= req_x;
            draw_y     <= req_y;
            draw_color <= req_color;
            draw_gap   <= req_gap;
        end
    end

    // ----------------------------------------
    // Game FSM
    // ----------------------------------------
    always_ff @(posedge CLOCK_50 or negedge resetn) begin
        if (!resetn) begin
            state     <= S_FOOD;
            heading   <= snake_pkg::DIR_RIGHT;
            seg       <= '0;
            ate       <= 1'b0;
            len       <= LW'(INIT_LEN);
            score     <= 8'd0;
            game_over <= 1'b0;
            food_x    <= snake_pkg::cell_x_t'(100);
            food_y    <= snake_pkg::cell_y_t'(60);
            for (int i = 0; i < MAX_LEN; i++) begin
                body_x[i] <= snake_pkg::cell_x_t'(snake_pkg::GRID_W / 2 - i * STEP);
                body_y[i] <= snake_pkg::cell_y_t'(snake_pkg::GRID_H / 2);
            end
        end else begin
            // No reversal onto the neck
            if ((dir ^ heading) != 2'b01) begin
                heading <= dir;
            end
            case (state)
                S_FOOD: if (hs_done) begin
                    state <= ate ? S_WAIT : S_SEGS;
                    ate   <= 1'b0;
                    seg   <= '0;
                end
                S_SEGS: if (hs_done) begin
                    if (seg == tail_idx) begin
                        state <= ate ? S_FOOD : S_WAIT;
                    end else begin
                        seg <= seg + 1'b1;
                    end
                end
                S_WAIT: if (tick) begin
                    mv_x <= nx;
                    mv_y <= ny;
                    if (wall || self_hit) begin
                        game_over <= 1'b1;
                        state     <= S_OVER;
                    end else begin
                        ate   <= eat;
                        state <= S_ERASE;
                    end
                end
                S_ERASE: if (hs_done) begin
                    state <= S_MOVE;
                end
                S_MOVE: begin
                    for (int i = MAX_LEN - 1; i > 0; i--) begin
                        body_x[i] <= body_x[i-1];
                        body_y[i] <= body_y[i-1];
                    end
                    body_x[0] <= mv_x;
                    body_y[0] <= mv_y;
                    if (ate) begin
                        score  <= score + 8'd1;
                        food_x <= snake_pkg::cell_x_t'(
                            (lfsr[7:0] % (snake_pkg::GRID_W / STEP)) * STEP);
                        food_y <= snake_pkg::cell_y_t'(
                            (lfsr[14:8] % (snake_pkg::GRID_H / STEP)) * STEP);
                        if (len < MAX_LEN) begin
                            len <= len + 1'b1;
                        end
                    end
                    seg   <= '0;
                    state <= S_SEGS;
                end
                default: ;
            endcase
        end
    end

    // Painter must already have dropped its ack when a new request starts
    a_req_after_ack: assert property (
        @(posedge CLOCK_50) disable iff (!resetn) $rose(draw_req) |-> !draw_ack
    );

endmodule

//--- source/block_painter.sv
`timescale 1ns/1ps

module block_painter #(
    parameter int STEP  = 4,
    parameter int SCALE = 4,
    parameter int GAP   = 4
) (
    input  logic               CLOCK_50,
    input  logic               resetn,
    input  logic               draw_req,
    input  snake_pkg::cell_x_t draw_x,
    input  snake_pkg::cell_y_t draw_y,
    input  snake_pkg::color_t  draw_color,
    input  logic               draw_gap,
    output logic               draw_ack,
    output snake_pkg::pix_x_t  pix_x,
    output snake_pkg::pix_y_t  pix_y,
    output snake_pkg::color_t  pix_color,
    output logic               pix_we
);

    // Block edge in pixels
    localparam int BLK = STEP * SCALE;
    localparam int OW  = $clog2(BLK);

    typedef enum logic [1:0] {P_IDLE, P_STREAM, P_ACK} pstate_t;

    pstate_t       state;
    logic [OW-1:0] off_x;
    logic [OW-1:0] off_y;
    logic          last_pix;
    logic          in_gap;

    assign last_pix = (off_x == OW'(BLK - 1)) && (off_y == OW'(BLK - 1));

    // Row-major scan, one pixel per clock
    always_ff @(posedge CLOCK_50 or negedge resetn) begin
        if (!resetn) begin
            state <= P_IDLE;
            off_x <= '0;
            off_y <= '0;
        end else begin
            case (state)
                P_IDLE: if (draw_req) begin
                    state <= P_STREAM;
                end
                P_STREAM: begin
                    if (last_pix) begin
                        off_x <= '0;
                        off_y <= '0;
                        state <= P_ACK;
                    end else if (off_x == OW'(BLK - 1)) begin
                        off_x <= '0;
                        off_y <= off_y + 1'b1;
                    end else begin
                        off_x <= off_x + 1'b1;
                    end
                end
                default: if (!draw_req) begin
                    state <= P_IDLE;
                end
            endcase
        end
    end

    // Request fields stay put until the ack is seen
    assign pix_we    = (state == P_STREAM);
    assign draw_ack  = (state == P_ACK);
    assign pix_x     = snake_pkg::pix_x_t'(draw_x) * snake_pkg::pix_x_t'(SCALE)
                     + snake_pkg::pix_x_t'(off_x);
    assign pix_y     = snake_pkg::pix_y_t'(draw_y) * snake_pkg::pix_y_t'(SCALE)
                     + snake_pkg::pix_y_t'(off_y);
    assign in_gap    = draw_gap && (int'(off_x) >= BLK - GAP || int'(off_y) >= BLK - GAP);
    assign pix_color = in_gap ? snake_pkg::BG_COLOR : draw_color;

endmodule

//--- source/score_display.sv
`timescale 1ns/1ps

module score_display (
    input  logic [7:0] score,
    output logic [6:0] hex0,
    output logic [6:0] hex1
);

    logic [3:0] ones;
    logic [3:0] tens;

    // Segment patterns, active low, gfedcba
    function automatic logic [6:0] seg7(input logic [3:0] v);
        case (v)
            4'h0: seg7 = 7'b1000000;
            4'h1: seg7 = 7'b1111001;
            4'h2: seg7 = 7'b0100100;
            4'h3: seg7 = 7'b0110000;
            4'h4: seg7 = 7'b0011001;
            4'h5: seg7 = 7'b0010010;
            4'h6: seg7 = 7'b0000010;
            4'h7: seg7 = 7'b1111000;
            4'h8: seg7 = 7'b0000000;
            4'h9: seg7 = 7'b0010000;
            4'hA: seg7 = 7'b0001000;
            4'hB: seg7 = 7'b0000011;
            4'hC: seg7 = 7'b1000110;
            4'hD: seg7 = 7'b0100001;
            4'hE: seg7 = 7'b0000110;
            default: seg7 = 7'b0001110;
        endcase
    endfunction

    // Two decimal digits, hundreds are not shown
    assign ones = 4'(score % 8'd10);
    assign tens = 4'((score / 8'd10) % 8'd10);
    assign hex0 = seg7(ones);
    assign hex1 = seg7(tens);

endmodule

//--- source/snake_top.sv
`timescale 1ns/1ps

module snake_top #(
    parameter int STEP        = 4,
    parameter int SCALE       = 4,
    parameter int GAP         = 4,
    parameter int MAX_LEN     = 64,
    parameter int INIT_LEN    = 8,
    parameter int TICK_CYCLES = 20_000_000
) (
    input  logic              CLOCK_50,
    input  logic              resetn,
    input  logic              ps2_clk,
    input  logic              ps2_dat,
    output snake_pkg::pix_x_t pix_x,
    output snake_pkg::pix_y_t pix_y,
    output snake_pkg::color_t pix_color,
    output logic              pix_we,
    output logic [6:0]        hex0,
    output logic [6:0]        hex1,
    output logic              game_over
);

    snake_pkg::dir_t    dir;
    logic               draw_req;
    logic               draw_ack;
    snake_pkg::cell_x_t draw_x;
    snake_pkg::cell_y_t draw_y;
    snake_pkg::color_t  draw_color;
    logic               draw_gap;
    logic [7:0]         score;

    ps2_direction_decoder u_decoder (
        .CLOCK_50 (CLOCK_50),
        .resetn   (resetn),
        .ps2_clk  (ps2_clk),
        .ps2_dat  (ps2_dat),
        .dir      (dir)
    );

    snake_engine #(
        .STEP        (STEP),
        .MAX_LEN     (MAX_LEN),
        .INIT_LEN    (INIT_LEN),
        .TICK_CYCLES (TICK_CYCLES)
    ) u_engine (
        .CLOCK_50   (CLOCK_50),
        .resetn     (resetn),
        .dir        (dir),
        .draw_req   (draw_req),
        .draw_x     (draw_x),
        .draw_y     (draw_y),
        .draw_color (draw_color),
        .draw_gap   (draw_gap),
        .draw_ack   (draw_ack),
        .score      (score),
        .game_over  (game_over)
    );

    block_painter #(
        .STEP  (STEP),
        .SCALE (SCALE),
        .GAP   (GAP)
    ) u_painter (
        .CLOCK_50   (CLOCK_50),
        .resetn     (resetn),
        .draw_req   (draw_req),
        .draw_x     (draw_x),
        .draw_y     (draw_y),
        .draw_color (draw_color),
        .draw_gap   (draw_gap),
        .draw_ack   (draw_ack),
        .pix_x      (pix_x),
        .pix_y      (pix_y),
        .pix_color  (pix_color),
        .pix_we     (pix_we)
    );

    score_display u_score (
        .score (score),
        .hex0  (hex0),
        .hex1  (hex1)
    );

endmodule

//--- dv/tb_snake_top.sv
`timescale 1ns/1ps

module tb_snake_top;

    localparam int TICK_CYCLES = 6000;
    localparam int STEP        = 4;
    localparam int SCALE       = 4;
    localparam int GAP         = 4;
    localparam int INIT_LEN    = 8;
    localparam int BLK         = STEP * SCALE;
    localparam int SEG_FG      = (BLK - GAP) * (BLK - GAP);
    localparam int SEG_BG      = BLK * BLK - SEG_FG;
    localparam int PS2_HALF    = 8;
    localparam int QUIET       = 40;
    localparam int CHK_NONE    = 0;
    localparam int CHK_STARTUP = 1;
    localparam int CHK_FOOD    = 2;
    localparam int CHK_FROZEN  = 3;

    typedef struct packed {
        logic [7:0] key;
        logic       brk;
        logic [7:0] ticks;
        logic [7:0] score;
        logic       over;
        logic [7:0] head_x;
        logic [6:0] head_y;
        logic [1:0] chk;
    } row_t;

    logic              CLOCK_50;
    logic              resetn;
    logic              ps2_clk;
    logic              ps2_dat;
    snake_pkg::pix_x_t pix_x;
    snake_pkg::pix_y_t pix_y;
    snake_pkg::color_t pix_color;
    logic              pix_we;
    logic [6:0]        hex0;
    logic [6:0]        hex1;
    logic              game_over;

    row_t   rows[$];
    int     blk_x[$], blk_y[$], blk_food[$], blk_snake[$], blk_bg[$];
    int     cur_x, cur_y, cur_food, cur_snake, cur_bg;
    bit     in_block = 1'b0;
    bit     after_erase = 1'b1;
    int     head_x = -1;
    int     head_y = -1;
    int     pix_total = 0;
    int     cyc;
    int     ticks_seen;
    int     n_errors = 0;
    longint limit_ns = 0;

    snake_top #(
        .TICK_CYCLES (TICK_CYCLES)
    ) dut (
        .CLOCK_50  (CLOCK_50),
        .resetn    (resetn),
        .ps2_clk   (ps2_clk),
        .ps2_dat   (ps2_dat),
        .pix_x     (pix_x),
        .pix_y     (pix_y),
        .pix_color (pix_color),
        .pix_we    (pix_we),
        .hex0      (hex0),
        .hex1      (hex1),
        .game_over (game_over)
    );

    initial begin
        CLOCK_50 = 1'b0;
        forever #10 CLOCK_50 = ~CLOCK_50;
    end

    // Game tick model, one tick every TICK_CYCLES clocks after reset
    always @(posedge CLOCK_50 or negedge resetn) begin
        if (!resetn) begin
            cyc        <= 0;
            ticks_seen <= 0;
        end else if (cyc == TICK_CYCLES - 1) begin
            cyc        <= 0;
            ticks_seen <= ticks_seen + 1;
        end else begin
            cyc <= cyc + 1;
        end
    end

    // ----------------------------------------
    // Pixel monitor
    // ----------------------------------------
    always @(negedge CLOCK_50) begin
        if (pix_we) begin
            if (!in_block) begin
                in_block  = 1'b1;
                cur_x     = int'(pix_x);
                cur_y     = int'(pix_y);
                cur_food  = 0;
                cur_snake = 0;
                cur_bg    = 0;
            end
            pix_total++;
            if (pix_color == snake_pkg::FOOD_COLOR) cur_food++;
            else if (pix_color == snake_pkg::SNAKE_COLOR) cur_snake++;
            else if (pix_color == snake_pkg::BG_COLOR) cur_bg++;
        end else if (in_block) begin
            in_block = 1'b0;
            blk_x.push_back(cur_x);
            blk_y.push_back(cur_y);
            blk_food.push_back(cur_food);
            blk_snake.push_back(cur_snake);
            blk_bg.push_back(cur_bg);
            // First segment after an erase is the head
            if (cur_bg == BLK * BLK) begin
                after_erase = 1'b1;
            end else if (cur_snake > 0 && after_erase) begin
                head_x      = cur_x / SCALE;
                head_y      = cur_y / SCALE;
                after_erase = 1'b0;
            end
        end
    end

    initial begin
        wait (limit_ns != 0);
        #(limit_ns);
        $display("Timeout: the run did not finish within %0d ns", limit_ns);
        $display("ERRORS FOUND");
        $finish;
    end

    // ----------------------------------------
    // Helpers
    // ----------------------------------------
    function automatic logic [6:0] digit_pattern(input int d);
        case (d)
            0: return 7'b1000000;
            1: return 7'b1111001;
            2: return 7'b0100100;
            3: return 7'b0110000;
            4: return 7'b0011001;
            5: return 7'b0010010;
            6: return 7'b0000010;
            7: return 7'b1111000;
            8: return 7'b0000000;
            default: return 7'b0010000;
        endcase
    endfunction

    task automatic report_mismatch(input string name, input longint exp, input longint act);
        n_errors++;
        $display("** Error at %0t ns: %s expected %0d, got %0d", $time, name, exp, act);
    endtask

    task automatic add_row(input logic [7:0] key, input bit brk, input int ticks,
                           input int score, input bit over, input int hx, input int hy,
                           input int chk);
        row_t r;
        r.key    = key;
        r.brk    = brk;
        r.ticks  = 8'(ticks);
        r.score  = 8'(score);
        r.over   = over;
        r.head_x = 8'(hx);
        r.head_y = 7'(hy);
        r.chk    = 2'(chk);
        rows.push_back(r);
    endtask

    // Start low, 8 data bits LSB first, odd parity, stop high
    task automatic send_byte(input logic [7:0] b);
        logic [10:0] bits;
        bits = {1'b1, ~^b, b, 1'b0};
        for (int i = 0; i < 11; i++) begin
            @(negedge CLOCK_50);
            ps2_dat = bits[i];
            repeat (PS2_HALF) @(negedge CLOCK_50);
            ps2_clk = 1'b0;
            repeat (PS2_HALF) @(negedge CLOCK_50);
            ps2_clk = 1'b1;
        end
        repeat (PS2_HALF + int'($urandom % 16)) @(negedge CLOCK_50);
    endtask

    task automatic send_arrow(input logic [7:0] code, input bit brk);
        send_byte(snake_pkg::PREFIX_EXT);
        if (brk) send_byte(snake_pkg::PREFIX_BREAK);
        send_byte(code);
    endtask

    // Redraw is over once pix_we stays low for a while
    task automatic wait_redraw_done();
        int quiet;
        quiet = 0;
        while (quiet < QUIET) begin
            @(negedge CLOCK_50);
            if (pix_we) quiet = 0;
            else quiet++;
        end
    endtask

    // ----------------------------------------
    // Stimulus table and checks
    // ----------------------------------------
    initial begin
        row_t        r;
        int          base;
        int          pix_before;
        int          errs_before;
        int          rows_failed;
        int          last;
        int          total_ticks;
        void'($urandom(32'h7057b494));
        rows_failed = 0;
        total_ticks = 0;
        resetn  = 1'b0;
        ps2_clk = 1'b1;
        ps2_dat = 1'b1;

        add_row(8'h00,                0,  0, 0, 0,  80, 60, CHK_STARTUP);
        add_row(8'h00,                0,  4, 0, 0,  96, 60, CHK_NONE);
        add_row(8'h00,                0,  1, 1, 0, 100, 60, CHK_FOOD);
        add_row(snake_pkg::KEY_LEFT,  0,  1, 1, 0, 104, 60, CHK_NONE);
        add_row(snake_pkg::KEY_UP,    0,  0, 1, 0, 104, 60, CHK_NONE);
        add_row(snake_pkg::KEY_DOWN,  0,  1, 1, 0, 104, 56, CHK_NONE);
        add_row(8'h00,                0,  2, 1, 0, 104, 48, CHK_NONE);
        add_row(snake_pkg::KEY_RIGHT, 1,  1, 1, 0, 104, 44, CHK_NONE);
        add_row(8'h00,                0, 12, 1, 1, 104,  0, CHK_NONE);
        add_row(8'h00,                0,  3, 1, 1, 104,  0, CHK_FROZEN);
        foreach (rows[i]) total_ticks += int'(rows[i].ticks);
        limit_ns = longint'(total_ticks + 3) * TICK_CYCLES * 20;

        repeat (8) @(negedge CLOCK_50);
        resetn = 1'b1;

        foreach (rows[i]) begin
            r           = rows[i];
            base        = ticks_seen;
            pix_before  = pix_total;
            errs_before = n_errors;
            if (r.key != 8'h00) send_arrow(r.key, r.brk);
            while (ticks_seen < base + int'(r.ticks)) @(negedge CLOCK_50);
            wait_redraw_done();

            if (hex0 !== digit_pattern(r.score % 10))
                report_mismatch("hex0", digit_pattern(r.score % 10), hex0);
            if (hex1 !== digit_pattern((r.score / 10) % 10))
                report_mismatch("hex1", digit_pattern((r.score / 10) % 10), hex1);
            if (game_over !== r.over) report_mismatch("game_over", r.over, game_over);
            if (head_x != int'(r.head_x)) report_mismatch("head cell x", r.head_x, head_x);
            if (head_y != int'(r.head_y)) report_mismatch("head cell y", r.head_y, head_y);

            if (r.chk == CHK_STARTUP) begin
                if (blk_x.size() != 1 + INIT_LEN) begin
                    report_mismatch("start-up block count", 1 + INIT_LEN, blk_x.size());
                end else begin
                    if (blk_food[0] != BLK * BLK)
                        report_mismatch("food block FOOD_COLOR pixels", BLK * BLK, blk_food[0]);
                    if (blk_x[0] != 100 * SCALE) report_mismatch("food pix_x", 400, blk_x[0]);
                    if (blk_y[0] != 60 * SCALE) report_mismatch("food pix_y", 240, blk_y[0]);
                    for (int b = 1; b <= INIT_LEN; b++) begin
                        if (blk_snake[b] != SEG_FG)
                            report_mismatch("segment SNAKE_COLOR pixels", SEG_FG, blk_snake[b]);
                        if (blk_bg[b] != SEG_BG)
                            report_mismatch("segment BG_COLOR pixels", SEG_BG, blk_bg[b]);
                    end
                end
            end
            if (r.chk == CHK_FOOD) begin
                last = blk_x.size() - 1;
                if (blk_food[last] != BLK * BLK)
                    report_mismatch("new food FOOD_COLOR pixels", BLK * BLK, blk_food[last]);
                if (blk_x[last] % BLK != 0)
                    report_mismatch("new food pix_x mod 16", 0, blk_x[last] % BLK);
                if (blk_y[last] % BLK != 0)
                    report_mismatch("new food pix_y mod 16", 0, blk_y[last] % BLK);
                if (blk_x[last] == 400 && blk_y[last] == 240) begin
                    n_errors++;
                    $display("New food was painted again at the old food origin");
                end
            end
            if (r.chk == CHK_FROZEN && pix_total != pix_before)
                report_mismatch("pix_we pulses after game over", 0, pix_total - pix_before);

            if (n_errors != errs_before) rows_failed++;
            $display("Row %0d %s at %0t ns", i, (n_errors == errs_before) ? "passed" : "failed",
                     $time);
        end

        $display("Rows: %0d run, %0d failed, %0d mismatches", rows.size(), rows_failed,
                 n_errors);
        if (n_errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- snake_top.f
source/snake_pkg.sv
source/ps2_direction_decoder.sv
source/snake_engine.sv
source/block_painter.sv
source/score_display.sv
source/snake_top.sv
dv/tb_snake_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_snake_top \
    -f snake_top.f --Mdir obj_dir -o tb_snake_top
./obj_dir/tb_snake_top | tee sim.log

if grep -q "ERRORS FOUND" sim.log; then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation passed"
